// File: include/vgaText_config.svh
`ifndef VGATEXT_CONFIG_SVH
`define VGATEXT_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~ Raster, 640x480 at 60 Hz
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// ~~~~~~~~~~~~~~~~~~~~ Cells and prompt window
`define CELL_W 8                // Pixels per character cell
`define CELL_H 16               // Lines per cell, each glyph row shown twice
`define WIN_COLS 16
`define WIN_ROWS 8

`define RST_FG 12'hFF0          // Yellow text
`define RST_BG 12'h008          // Dark blue box
`define RST_ORIGIN_COL 32
`define RST_ORIGIN_ROW 10

`define PIPE_DEPTH 3            // Raster to pixel latency of the renderer

`endif

// File: verilog/vgaPkg.sv
package vgaPkg;

    // Only the glyphs the chest prompt needs
    typedef enum logic [6:0] {
        SPACE = 7'd0,
        A,
        I,
        K,
        N,
        O,
        R,
        S,
        T,
        W,
        Y,
        Z,
        C_1,
        NKL,                        // Left bracket
        NKR                         // Right bracket
    } charCode;

    typedef enum logic [1:0] {
        SET_FG,
        SET_BG,
        SET_ORIGIN,                 // data[11:7] row, data[6:0] column
        SET_ENABLE                  // data[0]
    } cfgOpcode;

    typedef struct packed {
        logic        valid;
        cfgOpcode    op;
        logic [11:0] data;
    } cfgWrite;

    typedef struct packed {
        logic [9:0] hCount;
        logic [9:0] vCount;
        logic       hSync;          // Active low
        logic       vSync;          // Active low
        logic       active;
    } rasterSync;

    typedef struct packed {
        logic [11:0] fg;
        logic [11:0] bg;
        logic [6:0]  originCol;     // In cells
        logic [4:0]  originRow;     // In cells
        logic        enable;
    } overlaySettings;

endpackage

// File: verilog/vgaTiming.sv
`include "vgaText_config.svh"

module vgaTiming (
    input  logic              clk,
    input  logic              rstN,
    output vgaPkg::rasterSync raster
);

    logic [9:0] hCount;
    logic [9:0] vCount;
    logic       lineEnd;
    logic       frameEnd;

    assign lineEnd  = (hCount == 10'(`H_TOTAL - 1));
    assign frameEnd = (vCount == 10'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            vCount <= frameEnd ? '0 : vCount + 10'd1;  // Line counter steps once per line
        end else begin
            hCount <= hCount + 10'd1;
        end
    end

    // Sync pulses sit after the front porch
    always_comb begin
        raster.hCount = hCount;
        raster.vCount = vCount;
        raster.hSync  = !((hCount >= `H_ACTIVE + `H_FRONT) &&
                          (hCount < `H_ACTIVE + `H_FRONT + `H_SYNC));
        raster.vSync  = !((vCount >= `V_ACTIVE + `V_FRONT) &&
                          (vCount < `V_ACTIVE + `V_FRONT + `V_SYNC));
        raster.active = (hCount < `H_ACTIVE) && (vCount < `V_ACTIVE);
    end

    countersInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        (hCount < `H_TOTAL) && (vCount < `V_TOTAL)
    );

endmodule

// File: verilog/promptTextRom.sv
module promptTextRom (
    input  logic            clk,
    input  logic [7:0]      cellIndex,
    output vgaPkg::charCode code
);

    import vgaPkg::*;

    logic [3:0] row;
    logic [3:0] col;
    charCode    nextCode;

    assign row = cellIndex[7:4];                // Rows 8 and up lie outside the window
    assign col = cellIndex[3:0];

    always_comb begin
        case (row)
            4'd0: begin
                case (col)                      // Chest title
                    4'd1:    nextCode = S;
                    4'd2:    nextCode = K;
                    4'd3:    nextCode = R;
                    4'd4:    nextCode = Z;
                    4'd5:    nextCode = Y;
                    4'd6:    nextCode = N;
                    4'd7:    nextCode = I;
                    4'd8:    nextCode = A;
                    default: nextCode = SPACE;
                endcase
            end
            4'd6: begin
                case (col)                      // Key hint for opening the chest
                    4'd4:    nextCode = NKL;
                    4'd5:    nextCode = C_1;
                    4'd6:    nextCode = NKR;
                    4'd8:    nextCode = O;
                    4'd9:    nextCode = T;
                    4'd10:   nextCode = W;
                    4'd11:   nextCode = O;
                    4'd12:   nextCode = R;
                    4'd13:   nextCode = Z;
                    default: nextCode = SPACE;
                endcase
            end
            default: nextCode = SPACE;
        endcase
    end

    always_ff @(posedge clk) begin
        code <= nextCode;
    end

endmodule

// File: verilog/glyphRom.sv
module glyphRom (
    input  logic            clk,
    input  vgaPkg::charCode code,
    input  logic [2:0]      glyphRow,
    output logic [7:0]      bits
);

    import vgaPkg::*;

    logic [0:7][7:0] glyph;                     // Entry 0 is the top row, bit 7 the left pixel

    always_comb begin
        case (code)
            A:   glyph = {8'b00000000, 8'b00011000,
                          8'b00111100, 8'b01100110,
                          8'b01100110, 8'b01111110,
                          8'b01100110, 8'b00000000};
            I:   glyph = {8'b00000000, 8'b00111100,
                          8'b00011000, 8'b00011000,
                          8'b00011000, 8'b00011000,
                          8'b00111100, 8'b00000000};
            K:   glyph = {8'b00000000, 8'b01100110,
                          8'b01101100, 8'b01111000,
                          8'b01111000, 8'b01101100,
                          8'b01100110, 8'b00000000};
            N:   glyph = {8'b00000000, 8'b01100110,
                          8'b01110110, 8'b01111110,
                          8'b01111110, 8'b01101110,
                          8'b01100110, 8'b00000000};
            O:   glyph = {8'b00000000, 8'b00111100,
                          8'b01100110, 8'b01100110,
                          8'b01100110, 8'b01100110,
                          8'b00111100, 8'b00000000};
            R:   glyph = {8'b00000000, 8'b01111100,
                          8'b01100110, 8'b01100110,
                          8'b01111100, 8'b01101100,
                          8'b01100110, 8'b00000000};
            S:   glyph = {8'b00000000, 8'b00111110,
                          8'b01100000, 8'b00111100,
                          8'b00000110, 8'b00000110,
                          8'b01111100, 8'b00000000};
            T:   glyph = {8'b00000000, 8'b01111110,
                          8'b00011000, 8'b00011000,
                          8'b00011000, 8'b00011000,
                          8'b00011000, 8'b00000000};
            W:   glyph = {8'b00000000, 8'b01100011,
                          8'b01100011, 8'b01101011,
                          8'b01111111, 8'b01110111,
                          8'b01100011, 8'b00000000};
            Y:   glyph = {8'b00000000, 8'b01100110,
                          8'b01100110, 8'b00111100,
                          8'b00011000, 8'b00011000,
                          8'b00011000, 8'b00000000};
            Z:   glyph = {8'b00000000, 8'b01111110,
                          8'b00001100, 8'b00011000,
                          8'b00110000, 8'b01100000,
                          8'b01111110, 8'b00000000};
            C_1: glyph = {8'b00000000, 8'b00011000,
                          8'b00111000, 8'b00011000,
                          8'b00011000, 8'b00011000,
                          8'b01111110, 8'b00000000};
            NKL: glyph = {8'b00000000, 8'b00111100,
                          8'b00110000, 8'b00110000,
                          8'b00110000, 8'b00110000,
                          8'b00111100, 8'b00000000};
            NKR: glyph = {8'b00000000, 8'b00111100,
                          8'b00001100, 8'b00001100,
                          8'b00001100, 8'b00001100,
                          8'b00111100, 8'b00000000};
            default: glyph = '0;                // SPACE and any code without a bitmap
        endcase
    end

    always_ff @(posedge clk) begin
        bits <= glyph[glyphRow];
    end

endmodule

// File: verilog/overlayConfig.sv
`include "vgaText_config.svh"

module overlayConfig (
    input  logic                   clk,
    input  logic                   rstN,
    input  vgaPkg::cfgWrite        cfgIn,
    input  vgaPkg::rasterSync      raster,
    output vgaPkg::overlaySettings settings
);

    import vgaPkg::*;

    localparam int maxCol = `H_ACTIVE / `CELL_W - `WIN_COLS;
    localparam int maxRow = `V_ACTIVE / `CELL_H - `WIN_ROWS;

    localparam overlaySettings rstSettings = '{
        fg:        12'(`RST_FG),
        bg:        12'(`RST_BG),
        originCol: 7'(`RST_ORIGIN_COL),
        originRow: 5'(`RST_ORIGIN_ROW),
        enable:    1'b1
    };

    overlaySettings pending;
    logic           frameEnd;

    // Loading on the last raster cycle makes the new values visible from pixel (0,0)
    assign frameEnd = (raster.hCount == 10'(`H_TOTAL - 1)) &&
                      (raster.vCount == 10'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending  <= rstSettings;
            settings <= rstSettings;
        end else begin
            if (cfgIn.valid) begin
                case (cfgIn.op)
                    SET_FG:     pending.fg <= cfgIn.data;
                    SET_BG:     pending.bg <= cfgIn.data;
                    SET_ORIGIN: begin
                        pending.originRow <= cfgIn.data[11:7];
                        pending.originCol <= cfgIn.data[6:0];
                    end
                    SET_ENABLE: pending.enable <= cfgIn.data[0];
                    default:    pending <= pending;
                endcase
            end
            if (frameEnd)
                settings <= pending;   // Whole frame is drawn with one set of values
        end
    end

    windowOnScreen: assert property (
        @(posedge clk) disable iff (!rstN)
        (settings.originCol <= maxCol) && (settings.originRow <= maxRow)
    );

endmodule

// File: verilog/textRenderer.sv
`include "vgaText_config.svh"

module textRenderer (
    input  logic                   clk,
    input  logic                   rstN,
    input  vgaPkg::rasterSync      raster,
    input  vgaPkg::overlaySettings settings,
    output logic                   hSync,
    output logic                   vSync,
    output logic [11:0]            rgb
);

    import vgaPkg::*;

    localparam int winWidth  = `WIN_COLS * `CELL_W;
    localparam int winHeight = `WIN_ROWS * `CELL_H;

    typedef struct packed {
        logic hSync;
        logic vSync;
        logic active;
        logic inWin;
    } pixelFlags;

    localparam pixelFlags idleFlags = '{hSync: 1'b1, vSync: 1'b1, active: 1'b0, inWin: 1'b0};

    logic [9:0] winLeft;
    logic [9:0] winTop;
    logic [9:0] relX;
    logic [9:0] relY;
    logic [7:0] cellIndex;
    charCode    code;
    pixelFlags  flags0;
    pixelFlags  flags1;
    pixelFlags  flags2;
    logic [2:0] glyphRow1;
    logic [2:0] pixCol1;
    logic [2:0] pixCol2;
    logic [7:0] glyphBits;

    // ~~~~~~~~~~~~~~~~~~~~ Stage 1
    assign winLeft   = 10'(settings.originCol * `CELL_W);
    assign winTop    = 10'(settings.originRow * `CELL_H);
    assign relX      = raster.hCount - winLeft;
    assign relY      = raster.vCount - winTop;
    assign cellIndex = {1'b0, relY[6:4], relX[6:3]};   // Row times 16 plus column

    always_comb begin
        flags0.hSync  = raster.hSync;
        flags0.vSync  = raster.vSync;
        flags0.active = raster.active;
        flags0.inWin  = settings.enable && raster.active &&
                        (raster.hCount >= winLeft) && (relX < winWidth) &&
                        (raster.vCount >= winTop) && (relY < winHeight);
    end

    promptTextRom textRom0 (.clk(clk), .cellIndex(cellIndex), .code(code));

    // ~~~~~~~~~~~~~~~~~~~~ Stage 2
    glyphRom glyphRom0 (.clk(clk), .code(code), .glyphRow(glyphRow1), .bits(glyphBits));

    always_ff @(posedge clk) begin
        glyphRow1 <= relY[3:1];                         // Each glyph row covers two lines
        pixCol1   <= relX[2:0];
        pixCol2   <= pixCol1;
    end

    // ~~~~~~~~~~~~~~~~~~~~ Stage 3
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags1 <= idleFlags;
            flags2 <= idleFlags;
            hSync  <= 1'b1;
            vSync  <= 1'b1;
            rgb    <= '0;
        end else begin
            flags1 <= flags0;
            flags2 <= flags1;
            hSync  <= flags2.hSync;
            vSync  <= flags2.vSync;
            if (!flags2.inWin)
                rgb <= '0;
            else
                rgb <= glyphBits[3'd7 - pixCol2] ? settings.fg : settings.bg;
        end
    end

    blankIsBlack: assert property (
        @(posedge clk) disable iff (!rstN)
        !$past(flags2.active) |-> (rgb == '0)
    );

endmodule

// File: verilog/textOverlayTop.sv
module textOverlayTop (
    input  logic            clk,
    input  logic            rstN,
    input  vgaPkg::cfgWrite cfgIn,
    output logic            hSync,
    output logic            vSync,
    output logic [11:0]     rgb
);

    import vgaPkg::*;

    rasterSync      raster;
    overlaySettings settings;

    vgaTiming timing0 (
        .clk    (clk),
        .rstN   (rstN),
        .raster (raster)
    );

    overlayConfig config0 (
        .clk      (clk),
        .rstN     (rstN),
        .cfgIn    (cfgIn),
        .raster   (raster),
        .settings (settings)
    );

    // Outputs trail the raster counters by three cycles
    textRenderer renderer0 (
        .clk      (clk),
        .rstN     (rstN),
        .raster   (raster),
        .settings (settings),
        .hSync    (hSync),
        .vSync    (vSync),
        .rgb      (rgb)
    );

endmodule

// File: test/textOverlayTb.sv
`include "vgaText_config.svh"

module textOverlayTb;

    timeunit 1ns;
    timeprecision 100ps;

    import vgaPkg::*;

    localparam int frameCycles = `H_TOTAL * `V_TOTAL;
    localparam int testFrames  = 8;     // Lock, four random frames, disable, blank, return
    localparam int cycleLimit  = (testFrames + 1) * frameCycles;

    logic           clk = 1'b0;
    logic           rstN;
    cfgWrite        cfgIn;
    logic           hSync;
    logic           vSync;
    logic [11:0]    rgb;

    overlaySettings curSet;
    overlaySettings pendSet;
    logic [127:0]   fgSeen;             // One flag per window cell, row times 16 plus column
    int             xPos = 0;
    int             yPos = 0;
    logic           prevH = 1'b1;
    logic           prevV = 1'b1;
    logic           hLocked = 1'b0;
    logic           locked = 1'b0;
    logic           frameLive = 1'b0;
    logic           hSeen = 1'b0;
    logic           vSeen = 1'b0;
    int             hCycles = 0;
    int             vCycles = 0;
    int             sinceReset = 0;
    int             glyphFrames = 0;
    int             errors = 0;
    int             cycles = 0;

    textOverlayTop dut0 (
        .clk   (clk),
        .rstN  (rstN),
        .cfgIn (cfgIn),
        .hSync (hSync),
        .vSync (vSync),
        .rgb   (rgb)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic bit hasGlyph(input int row, input int col);
        string title = "SKRZYNIA";
        string hint  = "[1] OTWORZ";
        if (row == 0)
            return (col >= 1) && (col < 1 + title.len());
        if (row == 6 && col >= 4 && col < 4 + hint.len())
            return hint[col - 4] != " ";
        return 1'b0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~ Output stream model
    task measureSync();
        hCycles++;
        vCycles++;
        if (prevH && !hSync) begin
            if (hSeen)
                checkValue("hSync period", `H_TOTAL, hCycles);
            hSeen   = 1'b1;
            hCycles = 0;
        end
        if (!prevH && hSync && hSeen)
            checkValue("hSync width", `H_SYNC, hCycles);
        if (prevV && !vSync) begin
            if (vSeen)
                checkValue("vSync period", frameCycles, vCycles);
            vSeen   = 1'b1;
            vCycles = 0;
        end
        if (!prevV && vSync && vSeen)
            checkValue("vSync width", `V_SYNC * `H_TOTAL, vCycles);
    endtask

    task advancePosition();
        if (prevH && !hSync) begin
            xPos    = `H_ACTIVE + `H_FRONT;    // Pulse starts after the front porch
            hLocked = 1'b1;
        end else if (xPos == `H_TOTAL - 1) begin
            xPos = 0;
            yPos = (yPos == `V_TOTAL - 1) ? 0 : yPos + 1;
        end else begin
            xPos++;
        end
        if (prevV && !vSync) begin
            yPos = `V_ACTIVE + `V_FRONT;
            if (hLocked)
                locked = 1'b1;
        end
    endtask

    task automatic checkPixel();
        int left;
        int top;
        int col;
        int row;
        left = curSet.originCol * `CELL_W;
        top  = curSet.originRow * `CELL_H;
        if (xPos >= `H_ACTIVE || yPos >= `V_ACTIVE || !curSet.enable ||
            xPos < left || xPos >= left + `WIN_COLS * `CELL_W ||
            yPos < top || yPos >= top + `WIN_ROWS * `CELL_H) begin
            checkValue("rgb", 12'h000, rgb);
        end else begin
            col = (xPos - left) / `CELL_W;
            row = (yPos - top) / `CELL_H;
            if (!hasGlyph(row, col))
                checkValue("rgb", curSet.bg, rgb);
            else if (rgb == curSet.fg)
                fgSeen[row * `WIN_COLS + col] = 1'b1;
            else
                checkValue("rgb", curSet.bg, rgb);  // Glyph cells hold only fg or bg
        end
    endtask

    task automatic verifyGlyphCells();
        for (int r = 0; r < `WIN_ROWS; r++) begin
            for (int c = 0; c < `WIN_COLS; c++) begin
                if (hasGlyph(r, c))
                    checkValue($sformatf("fg pixel in cell %0d,%0d", r, c), 1,
                               fgSeen[r * `WIN_COLS + c]);
            end
        end
        glyphFrames++;
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            sinceReset++;
            if (sinceReset <= `PIPE_DEPTH) begin
                checkValue("hSync", 1, hSync);
                checkValue("vSync", 1, vSync);
                checkValue("rgb", 0, rgb);
            end
            measureSync();
            advancePosition();
            if (locked) begin
                if (xPos == 0 && yPos == 0) begin
                    curSet    = pendSet;       // New settings take effect on a frame boundary
                    fgSeen    = '0;
                    frameLive = 1'b1;
                end
                checkPixel();
                if (xPos == 0 && yPos == `V_ACTIVE && frameLive && curSet.enable)
                    verifyGlyphCells();
            end
            prevH = hSync;
            prevV = vSync;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~ Stimulus
    task automatic waitForLine(input int line);
        @(posedge clk);
        while (!(locked && xPos == 0 && yPos == line))
            @(posedge clk);
    endtask

    task automatic sendConfig(input cfgOpcode op, input logic [11:0] data);
        #2;
        cfgIn = '{valid: 1'b1, op: op, data: data};
        case (op)
            SET_FG:     pendSet.fg = data;
            SET_BG:     pendSet.bg = data;
            SET_ORIGIN: begin
                pendSet.originRow = data[11:7];
                pendSet.originCol = data[6:0];
            end
            default:    pendSet.enable = data[0];
        endcase
        @(posedge clk);
        #2;
        cfgIn = '0;
        @(posedge clk);
    endtask

    task automatic sendRandomSettings();
        logic [4:0] row;
        logic [6:0] col;
        row = 5'($urandom % 23);                // Keeps the window on screen
        col = 7'($urandom % 65);
        sendConfig(SET_FG, 12'($urandom));
        sendConfig(SET_BG, 12'($urandom));
        sendConfig(SET_ORIGIN, {row, col});
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Run timed out after %0d cycles before the test sequence finished",
                     cycles);
            $display("Finished with %0d errors", errors);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rstN  = 1'b0;
        cfgIn = '0;
        pendSet = '{fg: `RST_FG, bg: `RST_BG, originCol: `RST_ORIGIN_COL,
                    originRow: `RST_ORIGIN_ROW, enable: 1'b1};
        curSet = pendSet;
        void'($urandom(14));
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int f = 0; f < 4; f++) begin
            waitForLine(`V_ACTIVE / 2);         // Writes land mid frame
            sendRandomSettings();
        end
        waitForLine(`V_ACTIVE / 2);
        sendConfig(SET_ENABLE, 12'd0);
        waitForLine(`V_ACTIVE / 2);
        sendConfig(SET_ENABLE, 12'd1);
        waitForLine(0);
        waitForLine(`V_ACTIVE);
        checkValue("checked glyph frames", 6, glyphFrames);
        $display("Finished with %0d errors", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/vgaPkg.sv
verilog/vgaTiming.sv
verilog/promptTextRom.sv
verilog/glyphRom.sv
verilog/overlayConfig.sv
verilog/textRenderer.sv
verilog/textOverlayTop.sv
test/textOverlayTb.sv
